// ==== logic/smpc_pkg.sv ====
package smpc_pkg;

	typedef enum logic [7:0] {
		CMD_MSHON   = 8'h00,
		CMD_SSHON   = 8'h02,
		CMD_SSHOFF  = 8'h03,
		CMD_SNDON   = 8'h06,
		CMD_SNDOFF  = 8'h07,
		CMD_INTBACK = 8'h10,
		CMD_SETTIME = 8'h16,
		CMD_NMIREQ  = 8'h18,
		CMD_RESENAB = 8'h19,
		CMD_RESDISA = 8'h1A
	} cmd_t;

	localparam logic [15:0] WAIT_ACCEPT  = 16'd90;
	localparam logic [15:0] WAIT_POWER   = 16'd120;
	localparam logic [15:0] WAIT_INTBACK = 16'd800;
	localparam logic [15:0] WAIT_SETTIME = 16'd279;
	localparam logic [15:0] WAIT_NMI     = 16'd127;

	localparam logic [4:0] OREG_ECHO_IDX = 5'd31;

	localparam logic [6:0] REG_IREG0  = 7'h01;
	localparam logic [6:0] REG_IREG6  = 7'h0D;
	localparam logic [6:0] REG_COMREG = 7'h1F;
	localparam logic [6:0] REG_OREG0  = 7'h21;
	localparam logic [6:0] REG_OREG31 = 7'h5F;
	localparam logic [6:0] REG_SR     = 7'h61;
	localparam logic [6:0] REG_SF     = 7'h63;

	typedef struct packed {
		logic [15:0] year;
		logic [3:0]  weekday;
		logic [3:0]  month;     // 1..12, plain binary nibble
		logic [7:0]  day;
		logic [7:0]  hour;
		logic [7:0]  minute;
		logic [7:0]  second;
	} rtc_time_t;

	typedef struct packed {
		logic msh_res_n;
		logic msh_nmi_n;
		logic ssh_res_n;
		logic ssh_nmi_n;
		logic snd_res_n;
	} reset_lines_t;

	typedef struct packed {
		logic       valid;
		logic [4:0] idx;
		logic       status;     // 1 = status byte, 0 = command echo
	} oreg_req_t;

	typedef struct packed {
		logic [7:0]      comreg;
		logic [6:0][7:0] ireg;
		logic            cmd_new;
	} host_cmd_t;

endpackage

// ==== logic/smpc_oreg_ram.sv ====
`timescale 1ns/1ps

module smpc_oreg_ram (
	input  logic       CLK,
	input  logic [4:0] waddr,
	input  logic [7:0] wdata,
	input  logic       we,
	input  logic [4:0] raddr,
	output logic [7:0] q
);

	logic [7:0] mem [32];

	always_ff @(posedge CLK) begin
		if (we)
			mem[waddr] <= wdata;
	end

	assign q = mem[raddr];     // Read port is combinational

endmodule

// ==== logic/smpc_oreg_builder.sv ====
`timescale 1ns/1ps

module smpc_oreg_builder (
	input  logic                   CLK,
	input  logic                   RST_N,
	input  smpc_pkg::oreg_req_t    oreg_req,
	input  smpc_pkg::rtc_time_t    now,
	input  smpc_pkg::reset_lines_t lines,
	input  logic                   resd,
	input  logic                   ste,
	input  logic [7:0]             comreg,
	input  logic [4:0]             oreg_raddr,
	output logic [7:0]             oreg_q
);
	import smpc_pkg::*;

	logic [7:0] status_byte;
	logic       we_q;
	logic [4:0] waddr_q;
	logic [7:0] wdata_q;

	always_comb begin
		case (oreg_req.idx)
			5'd0: status_byte = {ste, resd, 6'b000000};
			5'd1: status_byte = now.year[15:8];
			5'd2: status_byte = now.year[7:0];
			5'd3: status_byte = {now.weekday, now.month};
			5'd4: status_byte = now.day;
			5'd5: status_byte = now.hour;
			5'd6: status_byte = now.minute;
			5'd7: status_byte = now.second;
			5'd10: status_byte = {4'b0011, ~lines.msh_nmi_n, 2'b10, ~lines.snd_res_n};
			OREG_ECHO_IDX: status_byte = comreg;
			default: status_byte = 8'h00;
		endcase
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N)
			we_q <= 1'b0;
		else
			we_q <= oreg_req.valid;
	end

	always_ff @(posedge CLK) begin
		waddr_q <= oreg_req.idx;
		wdata_q <= status_byte;
	end

	smpc_oreg_ram u_oreg_ram (
		.CLK   (CLK),
		.waddr (waddr_q),
		.wdata (wdata_q),
		.we    (we_q),
		.raddr (oreg_raddr),
		.q     (oreg_q)
	);

endmodule

// ==== logic/smpc_host_regs.sv ====
`timescale 1ns/1ps

module smpc_host_regs (
	input  logic                CLK,
	input  logic                RST_N,
	input  logic                MRES_N,
	input  logic [6:1]          A,
	input  logic [7:0]          DI,
	input  logic                CS_N,
	input  logic                RW_N,
	input  logic [7:0]          oreg_q,
	input  logic                sf_clear,
	input  logic                sr_status,
	output smpc_pkg::host_cmd_t host,
	output logic [4:0]          oreg_raddr,
	output logic [7:0]          DO
);
	import smpc_pkg::*;

	logic [6:0]      addr;
	logic [6:0][7:0] ireg;
	logic [7:0]      comreg;
	logic            cmd_new;
	logic            sf;
	logic [1:0]      sr_hi;
	logic [7:0]      sr;
	logic            rw_n_old;
	logic            cs_n_old;
	logic            wr_stb;
	logic            rd_stb;

	assign addr = {A, 1'b1};
	assign wr_stb = !RW_N && rw_n_old && !CS_N;     // Falling RW_N while selected
	assign rd_stb = !CS_N && cs_n_old && RW_N;
	assign sr = {sr_hi, 2'b00, ireg[1][7:4]};
	assign oreg_raddr = 5'(A - 6'h10);

	assign host = '{comreg: comreg, ireg: ireg, cmd_new: cmd_new};

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			rw_n_old <= 1'b1;
			ireg <= '0;
			comreg <= '0;
			cmd_new <= 1'b0;
			sf <= 1'b0;
		end else begin
			rw_n_old <= RW_N;
			cmd_new <= 1'b0;
			if (sf_clear)
				sf <= 1'b0;
			if (wr_stb) begin
				if (addr >= REG_IREG0 && addr <= REG_IREG6) begin
					ireg[A[3:1]] <= DI;
				end else if (addr == REG_COMREG) begin
					comreg <= DI;
					cmd_new <= 1'b1;
				end else if (addr == REG_SF && DI[0]) begin
					sf <= 1'b1;     // Host hands the command over
				end
			end
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N)
			sr_hi <= 2'b00;
		else if (!MRES_N)
			sr_hi <= 2'b00;
		else if (sr_status)
			sr_hi <= 2'b01;
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			cs_n_old <= 1'b1;
			DO <= '0;
		end else begin
			cs_n_old <= CS_N;
			if (rd_stb) begin
				if (addr >= REG_OREG0 && addr <= REG_OREG31)
					DO <= oreg_q;
				else if (addr == REG_SR)
					DO <= sr;
				else if (addr == REG_SF)
					DO <= {7'b0000000, sf};
				else
					DO <= '0;
			end
		end
	end

endmodule

// ==== logic/smpc_rtc.sv ====
`timescale 1ns/1ps

module smpc_rtc #(
	parameter int TICKS_PER_SEC = 4000000
) (
	input  logic                CLK,
	input  logic                RST_N,
	input  logic                CE,
	input  logic                load,
	input  smpc_pkg::rtc_time_t load_time,
	output smpc_pkg::rtc_time_t now
);

	localparam int PW = $clog2(TICKS_PER_SEC + 1);

	logic [PW-1:0] presc;
	logic          sec_wrap;

	function automatic logic [7:0] bcd_inc(input logic [7:0] v);
		logic [7:0] r;
		r = v + 8'd1;
		if (v[3:0] == 4'd9)
			r = {v[7:4] + 4'd1, 4'd0};
		if (v == 8'h99)
			r = 8'h00;
		return r;
	endfunction

	// No leap years
	function automatic logic [7:0] last_day(input logic [3:0] m);
		case (m)
			4'd2: return 8'h28;
			4'd4, 4'd6, 4'd9, 4'd11: return 8'h30;
			default: return 8'h31;
		endcase
	endfunction

	assign sec_wrap = (presc == PW'(TICKS_PER_SEC - 1));

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			presc <= '0;
			now <= '{year: 16'h2024, weekday: 4'd0, month: 4'd1, day: 8'h01,
				hour: 8'h00, minute: 8'h00, second: 8'h00};
		end else if (load) begin
			presc <= '0;     // Restart the second on a new time
			now <= load_time;
		end else if (CE) begin
			presc <= sec_wrap ? '0 : presc + 1'b1;
			if (sec_wrap) begin
				if (now.second == 8'h59) begin
					now.second <= 8'h00;
					if (now.minute == 8'h59) begin
						now.minute <= 8'h00;
						if (now.hour == 8'h23) begin
							now.hour <= 8'h00;
							now.weekday <= (now.weekday == 4'd6) ? 4'd0 : now.weekday + 4'd1;
							if (now.day == last_day(now.month)) begin
								now.day <= 8'h01;
								if (now.month == 4'd12) begin
									now.month <= 4'd1;
									now.year[7:0] <= bcd_inc(now.year[7:0]);
									if (now.year[7:0] == 8'h99)
										now.year[15:8] <= bcd_inc(now.year[15:8]);
								end else begin
									now.month <= now.month + 4'd1;
								end
							end else begin
								now.day <= bcd_inc(now.day);
							end
						end else begin
							now.hour <= bcd_inc(now.hour);
						end
					end else begin
						now.minute <= bcd_inc(now.minute);
					end
				end else begin
					now.second <= bcd_inc(now.second);
				end
			end
		end
	end

endmodule

// ==== logic/smpc_command_seq.sv ====
`timescale 1ns/1ps

module smpc_command_seq (
	input  logic                   CLK,
	input  logic                   RST_N,
	input  logic                   CE,
	input  logic                   MRES_N,
	input  logic                   TIME_SET,
	input  smpc_pkg::host_cmd_t    host,
	output smpc_pkg::reset_lines_t lines,
	output logic                   resd,
	output logic                   ste,
	output logic                   mirq_n,
	output logic                   rtc_load,
	output smpc_pkg::oreg_req_t    oreg_req,
	output logic                   sf_clear,
	output logic                   sr_status
);
	import smpc_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_WAIT,
		S_COMMAND,
		S_EXEC,
		S_END
	} state_t;

	state_t      state;
	state_t      next_state;
	logic [15:0] wait_cnt;
	logic [4:0]  oreg_cnt;
	logic        cmd_pend;
	cmd_t        cmd;
	logic        is_intback;
	logic        intback_ok;
	logic        in_exec;

	assign cmd = cmd_t'(host.comreg);
	assign is_intback = (cmd == CMD_INTBACK);
	assign intback_ok = host.ireg[2] == 8'hF0 && host.ireg[0][0];     // Status-only form
	assign in_exec = (state == S_EXEC) && CE;

	assign rtc_load = in_exec && cmd == CMD_SETTIME;
	assign sr_status = in_exec && is_intback && oreg_cnt == 5'd31;
	assign sf_clear = (state == S_END) && CE;

	always_comb begin
		oreg_req = '0;
		if (in_exec) begin
			oreg_req.valid = 1'b1;
			oreg_req.idx = is_intback ? oreg_cnt : OREG_ECHO_IDX;
			oreg_req.status = is_intback;
		end
	end

	// Holds a command written while busy
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N)
			cmd_pend <= 1'b0;
		else if (host.cmd_new)
			cmd_pend <= 1'b1;
		else if (state == S_IDLE && CE)
			cmd_pend <= 1'b0;
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= S_IDLE;
			next_state <= S_IDLE;
			wait_cnt <= '0;
			oreg_cnt <= '0;
			lines <= '0;
			mirq_n <= 1'b1;
			resd <= 1'b1;
			ste <= 1'b0;
		end else if (!MRES_N) begin
			lines <= '{msh_res_n: 1'b1, msh_nmi_n: 1'b1, ssh_res_n: 1'b0,
				ssh_nmi_n: 1'b1, snd_res_n: 1'b0};
			mirq_n <= 1'b1;
			resd <= 1'b1;
			ste <= TIME_SET;
			state <= S_IDLE;
		end else if (CE) begin
			case (state)
				S_IDLE: begin
					if (cmd_pend) begin
						wait_cnt <= WAIT_ACCEPT;
						next_state <= S_COMMAND;
						state <= S_WAIT;
					end
				end
				S_WAIT: begin
					if (wait_cnt == 16'd0)
						state <= next_state;
					else
						wait_cnt <= wait_cnt - 16'd1;
				end
				S_COMMAND: begin
					oreg_cnt <= '0;
					next_state <= S_EXEC;
					state <= S_WAIT;
					case (cmd)
						CMD_MSHON, CMD_SSHON, CMD_SSHOFF, CMD_SNDON, CMD_SNDOFF:
							wait_cnt <= WAIT_POWER;
						CMD_INTBACK: begin
							if (intback_ok)
								wait_cnt <= WAIT_INTBACK;
							else
								state <= S_END;
						end
						CMD_SETTIME: wait_cnt <= WAIT_SETTIME;
						CMD_NMIREQ, CMD_RESENAB, CMD_RESDISA: wait_cnt <= WAIT_NMI;
						default: state <= S_EXEC;     // Unknown code is only echoed
					endcase
				end
				S_EXEC: begin
					state <= S_END;
					case (cmd)
						CMD_MSHON: begin
							lines.msh_res_n <= 1'b1;
							lines.msh_nmi_n <= 1'b1;
						end
						CMD_SSHON: begin
							lines.ssh_res_n <= 1'b1;
							lines.ssh_nmi_n <= 1'b1;
						end
						CMD_SSHOFF: begin
							lines.ssh_res_n <= 1'b0;
							lines.ssh_nmi_n <= 1'b1;
						end
						CMD_SNDON: lines.snd_res_n <= 1'b1;
						CMD_SNDOFF: lines.snd_res_n <= 1'b0;
						CMD_INTBACK: begin
							oreg_cnt <= oreg_cnt + 5'd1;
							if (oreg_cnt == 5'd31)
								mirq_n <= 1'b0;
							else
								state <= S_EXEC;     // One OREG byte per tick
						end
						CMD_SETTIME: ste <= 1'b1;
						CMD_NMIREQ: lines.msh_nmi_n <= 1'b0;
						CMD_RESENAB: resd <= 1'b0;
						CMD_RESDISA: resd <= 1'b1;
						default: ;
					endcase
				end
				S_END: begin
					mirq_n <= 1'b1;
					if (cmd == CMD_NMIREQ)
						lines.msh_nmi_n <= 1'b1;
					state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

// ==== logic/smpc_top.sv ====
`timescale 1ns/1ps

module smpc_top #(
	parameter int TICKS_PER_SEC = 4000000
) (
	input  logic       CLK,
	input  logic       RST_N,
	input  logic       CE,
	input  logic       MRES_N,
	input  logic       TIME_SET,
	input  logic [6:1] A,
	input  logic [7:0] DI,
	input  logic       CS_N,
	input  logic       RW_N,
	output logic [7:0] DO,
	output logic       MSHRES_N,
	output logic       MSHNMI_N,
	output logic       SSHRES_N,
	output logic       SSHNMI_N,
	output logic       SNDRES_N,
	output logic       MIRQ_N
);
	import smpc_pkg::*;

	host_cmd_t    host;
	reset_lines_t lines;
	oreg_req_t    oreg_req;
	rtc_time_t    now;
	rtc_time_t    load_time;
	logic         resd;
	logic         ste;
	logic         rtc_load;
	logic         sf_clear;
	logic         sr_status;
	logic [4:0]   oreg_raddr;
	logic [7:0]   oreg_q;

	// SETTIME takes the new time from IREG0..6
	assign load_time = '{year: {host.ireg[0], host.ireg[1]}, weekday: host.ireg[2][7:4],
		month: host.ireg[2][3:0], day: host.ireg[3], hour: host.ireg[4],
		minute: host.ireg[5], second: host.ireg[6]};

	assign MSHRES_N = lines.msh_res_n;
	assign MSHNMI_N = lines.msh_nmi_n;
	assign SSHRES_N = lines.ssh_res_n;
	assign SSHNMI_N = lines.ssh_nmi_n;
	assign SNDRES_N = lines.snd_res_n;

	smpc_host_regs u_host_regs (
		.CLK (CLK), .RST_N (RST_N), .MRES_N (MRES_N),
		.A (A), .DI (DI), .CS_N (CS_N), .RW_N (RW_N),
		.oreg_q (oreg_q), .sf_clear (sf_clear), .sr_status (sr_status),
		.host (host), .oreg_raddr (oreg_raddr), .DO (DO)
	);

	smpc_rtc #(.TICKS_PER_SEC(TICKS_PER_SEC)) u_rtc (
		.CLK (CLK), .RST_N (RST_N), .CE (CE),
		.load (rtc_load), .load_time (load_time), .now (now)
	);

	smpc_command_seq u_command_seq (
		.CLK (CLK), .RST_N (RST_N), .CE (CE), .MRES_N (MRES_N), .TIME_SET (TIME_SET),
		.host (host), .lines (lines), .resd (resd), .ste (ste), .mirq_n (MIRQ_N),
		.rtc_load (rtc_load), .oreg_req (oreg_req), .sf_clear (sf_clear),
		.sr_status (sr_status)
	);

	smpc_oreg_builder u_oreg_builder (
		.CLK (CLK), .RST_N (RST_N), .oreg_req (oreg_req), .now (now), .lines (lines),
		.resd (resd), .ste (ste), .comreg (host.comreg),
		.oreg_raddr (oreg_raddr), .oreg_q (oreg_q)
	);

endmodule

// ==== verification/smpc_tb_tasks.svh ====
`ifndef SMPC_TB_TASKS_SVH
`define SMPC_TB_TASKS_SVH

task automatic write_reg(input logic [6:0] addr, input logic [7:0] data);
	@(posedge CLK);
	#1;
	A = addr[6:1];
	DI = data;
	CS_N = 1'b0;
	RW_N = 1'b0;     // Strobe taken at the next edge
	@(posedge CLK);
	#1;
	CS_N = 1'b1;
	RW_N = 1'b1;
endtask

task automatic read_reg(input logic [6:0] addr, output logic [7:0] data);
	@(posedge CLK);
	#1;
	A = addr[6:1];
	RW_N = 1'b1;
	CS_N = 1'b0;
	@(posedge CLK);
	#1;
	data = DO;     // Registered on the edge just passed
	CS_N = 1'b1;
endtask

task automatic wait_sf_clear(input logic [7:0] code);
	logic [7:0] flag;
	int start;
	start = cycle_cnt;
	flag = 8'h01;
	while (flag[0]) begin
		if (cycle_cnt - start > SF_TIMEOUT) begin
			$display("Timeout: SF still set %0d cycles after command %02h", SF_TIMEOUT, code);
			stop_on_failure();
		end
		read_reg(REG_SF, flag);
	end
	busy = 1'b0;
endtask

function automatic logic [7:0] lcg_next();
	lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
	return lcg_state[23:16];
endfunction

`endif

// ==== verification/tb_smpc.sv ====
`timescale 1ns/1ps

module tb_smpc;
	import smpc_pkg::*;

	localparam int TICKS = 200;
	localparam int SF_TIMEOUT = 20000;

	logic         CLK;
	logic         RST_N;
	logic         CE;
	logic         MRES_N;
	logic         TIME_SET;
	logic [6:1]   A;
	logic [7:0]   DI;
	logic         CS_N;
	logic         RW_N;
	logic [7:0]   DO;
	logic         MSHRES_N;
	logic         MSHNMI_N;
	logic         SSHRES_N;
	logic         SSHNMI_N;
	logic         SNDRES_N;
	logic         MIRQ_N;

	logic [7:0]   ireg_val [7];
	logic [7:0]   power_seq [7];
	int           zero_idx [6];
	logic [31:0]  lcg_state;
	logic         busy;     // Host side view of SF
	logic         lines_valid;
	logic         mirq_old;
	int           mirq_pulses;
	int           nmi_low_cycles;
	int           cycle_cnt;
	reset_lines_t exp_lines;
	logic         exp_resd;
	logic         exp_ste;
	rtc_time_t    set_time;
	int           t_load;

	smpc_top #(.TICKS_PER_SEC(TICKS)) DUT (
		.CLK (CLK), .RST_N (RST_N), .CE (CE), .MRES_N (MRES_N), .TIME_SET (TIME_SET),
		.A (A), .DI (DI), .CS_N (CS_N), .RW_N (RW_N), .DO (DO),
		.MSHRES_N (MSHRES_N), .MSHNMI_N (MSHNMI_N), .SSHRES_N (SSHRES_N),
		.SSHNMI_N (SSHNMI_N), .SNDRES_N (SNDRES_N), .MIRQ_N (MIRQ_N)
	);

	always #10 CLK = ~CLK;

	always @(posedge CLK) begin
		cycle_cnt <= cycle_cnt + 1;
		mirq_old <= MIRQ_N;
		if (mirq_old && !MIRQ_N)
			mirq_pulses <= mirq_pulses + 1;
		if (lines_valid && !MSHNMI_N)
			nmi_low_cycles <= nmi_low_cycles + 1;
	end

	task automatic stop_on_failure();
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped at the first failing check");
	endtask

	`include "smpc_tb_tasks.svh"

	nmi_in_command: assert property (@(posedge CLK) disable iff (!lines_valid)
		!MSHNMI_N |-> busy)
		else begin
			$display("FAIL %0t: MSHNMI_N low while SF is clear", $time);
			stop_on_failure();
		end

	irq_in_command: assert property (@(posedge CLK) disable iff (!lines_valid)
		!MIRQ_N |-> busy)
		else begin
			$display("FAIL %0t: MIRQ_N low outside a command", $time);
			stop_on_failure();
		end

	task automatic check_value(input logic [15:0] got, input logic [15:0] exp,
		input string what);
		assert (got === exp)
		else begin
			$display("FAIL %0t: %s is %0h, expected %0h", $time, what, got, exp);
			stop_on_failure();
		end
	endtask

	function automatic logic [6:0] oreg_addr(input int idx);
		return 7'(REG_OREG0 + 2 * idx);     // Odd addresses from 0x21
	endfunction

	function automatic int from_bcd(input logic [7:0] b);
		return b[7:4] * 10 + b[3:0];
	endfunction

	function automatic logic [7:0] to_bcd(input int v);
		return {4'(v / 10), 4'(v % 10)};
	endfunction

	function automatic int days_in(input int m);
		if (m == 2)
			return 28;
		if (m == 4 || m == 6 || m == 9 || m == 11)
			return 30;
		return 31;
	endfunction

	// Reference clock, whole seconds after a load
	function automatic rtc_time_t advance_time(input rtc_time_t t0, input int secs);
		rtc_time_t t;
		int yr, mo, dy, wd;
		int hr, mi, se;
		yr = from_bcd(t0.year[15:8]) * 100 + from_bcd(t0.year[7:0]);
		mo = t0.month;
		dy = from_bcd(t0.day);
		wd = t0.weekday;
		hr = from_bcd(t0.hour);
		mi = from_bcd(t0.minute);
		se = from_bcd(t0.second) + secs;
		mi = mi + se / 60;
		se = se % 60;
		hr = hr + mi / 60;
		mi = mi % 60;
		while (hr >= 24) begin
			hr = hr - 24;
			wd = (wd + 1) % 7;
			dy = dy + 1;
			if (dy > days_in(mo)) begin
				dy = 1;
				mo = mo + 1;
				if (mo > 12) begin
					mo = 1;
					yr = yr + 1;
				end
			end
		end
		t.year = {to_bcd(yr / 100), to_bcd(yr % 100)};
		t.weekday = 4'(wd);
		t.month = 4'(mo);
		t.day = to_bcd(dy);
		t.hour = to_bcd(hr);
		t.minute = to_bcd(mi);
		t.second = to_bcd(se);
		return t;
	endfunction

	function automatic reset_lines_t power_rule(input reset_lines_t cur, input logic [7:0] code);
		reset_lines_t nxt;
		nxt = cur;
		case (code)
			CMD_MSHON: begin
				nxt.msh_res_n = 1'b1;
				nxt.msh_nmi_n = 1'b1;
			end
			CMD_SSHON: begin
				nxt.ssh_res_n = 1'b1;
				nxt.ssh_nmi_n = 1'b1;
			end
			CMD_SSHOFF: begin
				nxt.ssh_res_n = 1'b0;
				nxt.ssh_nmi_n = 1'b1;
			end
			CMD_SNDON: nxt.snd_res_n = 1'b1;
			CMD_SNDOFF: nxt.snd_res_n = 1'b0;
			default: ;
		endcase
		return nxt;
	endfunction

	task automatic fill_iregs();
		for (int i = 0; i < 7; i++)
			ireg_val[i] = lcg_next();
	endtask

	task automatic issue_command(input logic [7:0] code);
		for (int i = 0; i < 7; i++)
			write_reg(7'(REG_IREG0 + 2 * i), ireg_val[i]);
		write_reg(REG_COMREG, code);
		busy = 1'b1;
		write_reg(REG_SF, 8'h01);
		wait_sf_clear(code);
	endtask

	task automatic check_lines(input reset_lines_t exp, input string what);
		check_value(16'({MSHRES_N, MSHNMI_N, SSHRES_N, SSHNMI_N, SNDRES_N}), 16'(exp), what);
	endtask

	task automatic check_oreg(input int idx, input logic [7:0] exp, input string what);
		logic [7:0] got;
		read_reg(oreg_addr(idx), got);
		check_value(16'(got), 16'(exp), what);
	endtask

	task automatic check_sr(input logic [1:0] top);
		logic [7:0] sr_val;
		read_reg(REG_SR, sr_val);
		check_value(16'(sr_val[7:6]), 16'(top), "SR[7:6]");
		check_value(16'(sr_val[3:0]), 16'(ireg_val[1][7:4]), "SR[3:0]");
	endtask

	task automatic status_intback();
		int pulses;
		pulses = mirq_pulses;
		fill_iregs();
		ireg_val[0][0] = 1'b1;
		ireg_val[2] = 8'hF0;
		issue_command(CMD_INTBACK);
		check_value(16'(mirq_pulses - pulses), 16'd1, "MIRQ_N pulses in status INTBACK");
		check_sr(2'b01);
		check_oreg(0, {exp_ste, exp_resd, 6'b000000}, "OREG0 status byte");
	endtask

	task automatic master_reset(input logic time_set);
		@(posedge CLK);
		#1;
		TIME_SET = time_set;
		MRES_N = 1'b0;
		repeat (4) @(posedge CLK);
		#1;
		MRES_N = 1'b1;
		@(posedge CLK);
		#1;
		exp_lines = '{msh_res_n: 1'b1, msh_nmi_n: 1'b1, ssh_res_n: 1'b0, ssh_nmi_n: 1'b1,
			snd_res_n: 1'b0};
		exp_resd = 1'b1;
		exp_ste = time_set;
		check_lines(exp_lines, "lines after MRES_N");
		check_value(16'(MIRQ_N), 16'd1, "MIRQ_N after MRES_N");
		check_sr(2'b00);
	endtask

	task automatic check_clock(input rtc_time_t base, input int ticks);
		logic [7:0] b [8];
		rtc_time_t seen;
		int secs;
		logic hit;
		for (int i = 1; i <= 7; i++)
			read_reg(oreg_addr(i), b[i]);
		seen = '{year: {b[1], b[2]}, weekday: b[3][7:4], month: b[3][3:0], day: b[4],
			hour: b[5], minute: b[6], second: b[7]};
		secs = ticks / TICKS;
		hit = 1'b0;
		for (int d = -1; d <= 1; d++) begin
			if (secs + d >= 0 && advance_time(base, secs + d) === seen)
				hit = 1'b1;
		end
		assert (hit)
		else begin
			$display("FAIL %0t: clock %04h-%0d-%02h %02h:%02h:%02h wd %0d, %0d s after load",
				$time, seen.year, seen.month, seen.day, seen.hour, seen.minute, seen.second,
				seen.weekday, secs);
			stop_on_failure();
		end
	endtask

	initial begin
		int pulses;
		int nmi_before;
		logic [7:0] flag;
		CLK = 1'b0;
		RST_N = 1'b0;
		CE = 1'b1;
		MRES_N = 1'b1;
		TIME_SET = 1'b0;
		A = '0;
		DI = '0;
		CS_N = 1'b1;
		RW_N = 1'b1;
		lcg_state = 32'd35;
		busy = 1'b0;
		lines_valid = 1'b0;
		mirq_old = 1'b1;
		for (int i = 0; i < 7; i++)
			ireg_val[i] = 8'h00;
		power_seq = '{CMD_MSHON, CMD_SSHON, CMD_SNDON, CMD_SSHOFF, CMD_SNDOFF,
			CMD_SSHON, CMD_SNDON};
		zero_idx = '{8, 9, 12, 13, 14, 15};

		repeat (8) @(posedge CLK);
		#1;
		RST_N = 1'b1;
		check_lines('0, "lines after RST_N");
		check_value(16'(MIRQ_N), 16'd1, "MIRQ_N after RST_N");
		read_reg(REG_SF, flag);
		check_value(16'(flag), 16'd0, "SF after RST_N");
		check_sr(2'b00);

		// Master reset pulse
		master_reset(1'b1);
		lines_valid = 1'b1;

		// INTBACK that is not the status form
		fill_iregs();
		ireg_val[0][0] = 1'b1;
		ireg_val[2][7] = 1'b0;
		pulses = mirq_pulses;
		issue_command(CMD_INTBACK);
		check_value(16'(mirq_pulses - pulses), 16'd0, "MIRQ_N pulses in invalid INTBACK");
		check_sr(2'b00);

		for (int i = 0; i < 7; i++) begin
			fill_iregs();
			issue_command(power_seq[i]);
			exp_lines = power_rule(exp_lines, power_seq[i]);
			check_lines(exp_lines, "lines after power command");
			check_oreg(31, power_seq[i], "OREG31 echo");
			check_sr(2'b00);
		end

		fill_iregs();
		nmi_before = nmi_low_cycles;
		issue_command(CMD_NMIREQ);
		check_value(16'(nmi_low_cycles > nmi_before), 16'd1, "MSHNMI_N pulse in NMIREQ");
		check_lines(exp_lines, "lines after NMIREQ");
		check_oreg(31, CMD_NMIREQ, "OREG31 echo");

		fill_iregs();
		issue_command(CMD_RESENAB);
		exp_resd = 1'b0;
		status_intback();

		fill_iregs();
		issue_command(CMD_RESDISA);
		exp_resd = 1'b1;
		status_intback();

		// Second master reset with TIME_SET low
		fill_iregs();
		issue_command(CMD_RESENAB);
		master_reset(1'b0);
		status_intback();

		set_time = '{year: 16'h1999, weekday: 4'd5, month: 4'd12, day: 8'h31,
			hour: 8'h23, minute: 8'h59, second: 8'h58};
		ireg_val[0] = set_time.year[15:8];
		ireg_val[1] = set_time.year[7:0];
		ireg_val[2] = {set_time.weekday, set_time.month};
		ireg_val[3] = set_time.day;
		ireg_val[4] = set_time.hour;
		ireg_val[5] = set_time.minute;
		ireg_val[6] = set_time.second;
		issue_command(CMD_SETTIME);
		t_load = cycle_cnt;
		exp_ste = 1'b1;
		status_intback();
		check_clock(set_time, cycle_cnt - t_load);
		for (int i = 0; i < 6; i++)
			check_oreg(zero_idx[i], 8'h00, "unused OREG byte");
		check_lines(exp_lines, "lines at end");

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+verification
logic/smpc_pkg.sv
logic/smpc_oreg_ram.sv
logic/smpc_oreg_builder.sv
logic/smpc_host_regs.sv
logic/smpc_rtc.sv
logic/smpc_command_seq.sv
logic/smpc_top.sv
verification/tb_smpc.sv

// ==== Makefile ====
# Verilator simulation of the SMPC testbench

VERILATOR ?= verilator
TOP       ?= tb_smpc
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= ALL CHECKS PASSED
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator, run it and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_MSG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
